/* flist.f */
verilog/shell_pkg.sv
verilog/video_pkg.sv
verilog/dip_settings.sv
verilog/core_reset_ctl.sv
verilog/control_map.sv
verilog/video_formatter.sv
verilog/arcade_shell_top.sv
tests/tb_arcade_shell.sv

/* Makefile */
# Verilator build and run of the arcade shell testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_arcade_shell
FLIST     := flist.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SIM_LOG   := sim.log
SOURCES   := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(SIM_LOG)
	grep -q "^Simulation passed$$" $(SIM_LOG)

clean:
	rm -rf $(BUILD_DIR) $(SIM_LOG)

/* tests/tb_arcade_shell.sv */
// testbench for the arcade shell, single clock, inputs change on the falling edge
// outputs are sampled and checked on the falling edge against the model below
// reset hold is shortened to 40 cycles for the stretch tests

`timescale 1ns/1ps
`default_nettype none

module tb_arcade_shell import shell_pkg::*, video_pkg::*; ();

    localparam int hold_len = 40;

    logic         clk_74a = 1'b0;
    logic         reset;
    logic [31:0]  bridge_addr;
    logic         bridge_wr;
    logic [31:0]  bridge_wr_data;
    logic         dataslot_requestwrite;
    logic         dataslot_allcomplete;
    key_bits_t    cont1_key;
    key_bits_t    cont2_key;
    core_video_t  core_video;
    logic         pix_ce;

    logic [dip_width-1:0] dip_sw;
    logic                 btn_service_n;
    logic                 core_reset;
    game_inputs_t         game_in;
    video_out_t           video;

    // model state
    logic [1:0]   exp_ship;
    logic         exp_cabinet;
    logic         exp_bonus;
    logic [2:0]   exp_difficulty;
    logic         exp_demo_sounds;
    logic         exp_demo_music;
    logic         exp_service;
    logic         exp_req;
    logic         exp_downloading;
    int           exp_stretch_left;
    logic         exp_core_reset;
    game_inputs_t exp_game_in;
    logic [23:0]  exp_rgb;
    logic         exp_de;
    logic         exp_hs;
    logic         exp_vs;
    logic         exp_hs_prev;
    logic         exp_vs_prev;
    logic         rgb_known;

    // sync pulse counters, model and dut
    int hs_expected;
    int vs_expected;
    int hs_seen;
    int vs_seen;

    logic [31:0] rng_state = 32'he8192550;
    logic [31:0] word;
    int          wait_cycles;
    int          high_cycles;

    always #4 clk_74a = ~clk_74a;

    arcade_shell_top #(
        .reset_hold_cycles (hold_len)
    ) dut0 (
        .clk_74a               (clk_74a),
        .reset                 (reset),
        .bridge_addr           (bridge_addr),
        .bridge_wr             (bridge_wr),
        .bridge_wr_data        (bridge_wr_data),
        .dataslot_requestwrite (dataslot_requestwrite),
        .dataslot_allcomplete  (dataslot_allcomplete),
        .cont1_key             (cont1_key),
        .cont2_key             (cont2_key),
        .core_video            (core_video),
        .pix_ce                (pix_ce),
        .dip_sw                (dip_sw),
        .btn_service_n         (btn_service_n),
        .core_reset            (core_reset),
        .game_in               (game_in),
        .video                 (video)
    );

    ////////////////////////////////////////////////////////////////////////////
    // random numbers and reference rules

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        xorshift32 = x;
    endfunction

    task automatic next_random(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value = rng_state;
    endtask

    // switches are active low, pad byte on top and two below
    function automatic logic [dip_width-1:0] expected_dip();
        expected_dip = {8'hff, 7'h7f, ~exp_demo_music, ~exp_demo_sounds, ~exp_difficulty,
                        ~exp_bonus, ~exp_cabinet, ~exp_ship, 8'hff, 8'hff};
    endfunction

    // key bits by number, dpad 3:0, face 7:4, l1 8, select 14, start 15
    function automatic game_inputs_t map_keys(input logic [15:0] k1, input logic [15:0] k2);
        game_inputs_t g;
        g.coin_n    = ~{k2[14], k1[14]};
        g.start_n   = ~{k2[15], k1[15]};
        g.p1_joy_n  = ~k1[3:0];
        g.p2_joy_n  = ~k2[3:0];
        g.p1_fire_n = ~(|k1[7:4]);
        g.p2_fire_n = ~(|k2[7:4]);
        g.pause     = k1[8] | k2[8];
        map_keys = g;
    endfunction

    // bit replication up to 8 bits per channel
    function automatic logic [23:0] expand_colour(input core_video_t v);
        expand_colour = {v.r, v.r, v.r[2:1], v.g, v.g, v.g[2:1], v.b, v.b, v.b, v.b};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // model, advanced once per rising edge with the inputs held across it

    task automatic update_model();
        logic active;
        active = !(core_video.hblank || core_video.vblank);
        if (reset) begin
            exp_ship         = 2'd0;
            exp_cabinet      = 1'b0;
            exp_bonus        = 1'b0;
            exp_difficulty   = 3'd3;
            exp_demo_sounds  = 1'b0;
            exp_demo_music   = 1'b0;
            exp_service      = 1'b0;
            exp_req          = 1'b0;
            exp_downloading  = 1'b0;
            exp_stretch_left = 0;
            exp_core_reset   = 1'b1;
            exp_game_in      = map_keys(16'h0000, 16'h0000);
            exp_de           = 1'b0;
            exp_hs           = 1'b0;
            exp_vs           = 1'b0;
            exp_hs_prev      = 1'b0;
            exp_vs_prev      = 1'b0;
        end else begin
            // causes from before this edge show now
            exp_core_reset = exp_downloading || (exp_stretch_left > 0);
            if (exp_stretch_left > 0) begin
                exp_stretch_left = exp_stretch_left - 1;
            end else if (exp_req) begin
                exp_stretch_left = hold_len;
            end
            if (dataslot_requestwrite) begin
                exp_downloading = 1'b1;
            end else if (dataslot_allcomplete) begin
                exp_downloading = 1'b0;
            end

            exp_req = bridge_wr && (bridge_addr == addr_reset_req);
            if (bridge_wr) begin
                case (bridge_addr)
                    addr_ship_count:  exp_ship        = bridge_wr_data[1:0];
                    addr_cabinet:     exp_cabinet     = bridge_wr_data[0];
                    addr_bonus:       exp_bonus       = bridge_wr_data[0];
                    addr_difficulty:  exp_difficulty  = bridge_wr_data[2:0];
                    addr_demo_sounds: exp_demo_sounds = bridge_wr_data[0];
                    addr_demo_music:  exp_demo_music  = bridge_wr_data[0];
                    addr_service:     exp_service     = bridge_wr_data[0];
                    default: ;
                endcase
            end

            exp_game_in = map_keys(cont1_key, cont2_key);

            // video only moves on a pixel tick
            if (pix_ce) begin
                exp_rgb     = active ? expand_colour(core_video) : 24'h0;
                rgb_known   = 1'b1;
                exp_de      = active;
                exp_hs      = exp_hs_prev && !core_video.hs_n;
                exp_vs      = exp_vs_prev && !core_video.vs_n;
                exp_hs_prev = core_video.hs_n;
                exp_vs_prev = core_video.vs_n;
                hs_expected = hs_expected + int'(exp_hs);
                vs_expected = vs_expected + int'(exp_vs);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checks

    task automatic compare(input logic [63:0] actual, input logic [63:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("FAIL %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("ERROR at %0t ns: timed out waiting for %s", $time, what);
        $display("Simulation failed");
        $fatal(1, "timeout");
    endtask

    task automatic check_outputs();
        compare(64'(dip_sw), 64'(expected_dip()), "dip_sw");
        compare(64'(btn_service_n), 64'(!exp_service), "btn_service_n");
        compare(64'(core_reset), 64'(exp_core_reset), "core_reset");
        compare(64'(game_in), 64'(exp_game_in), "game_in");
        compare(64'(video.de), 64'(exp_de), "video de");
        compare(64'(video.hs), 64'(exp_hs), "video hs");
        compare(64'(video.vs), 64'(exp_vs), "video vs");
        if (rgb_known) begin
            compare(64'(video.rgb), 64'(exp_rgb), "video rgb");
        end
        // count fresh pulses only, holds between ticks are not new
        if (pix_ce && video.hs) begin
            hs_seen = hs_seen + 1;
        end
        if (pix_ce && video.vs) begin
            vs_seen = vs_seen + 1;
        end
    endtask

    // one clock, then model and compare; caller drives right after
    task automatic step_cycle();
        @(negedge clk_74a);
        update_model();
        check_outputs();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // random stimulus, no reset request address here

    task automatic drive_random();
        logic [31:0] ctl;
        logic [31:0] value;
        next_random(ctl);
        next_random(value);
        bridge_wr = ctl[0];
        case (ctl[3:1])
            3'd0: bridge_addr = addr_ship_count;
            3'd1: bridge_addr = addr_cabinet;
            3'd2: bridge_addr = addr_bonus;
            3'd3: bridge_addr = addr_difficulty;
            3'd4: bridge_addr = addr_demo_sounds;
            3'd5: bridge_addr = addr_demo_music;
            3'd6: bridge_addr = addr_service;
            // illegal, fully random or a legal top nibble with low bits set
            default: bridge_addr = ctl[16] ? value : (addr_bonus | {16'h0, value[15:1], 1'b1});
        endcase
        next_random(value);
        bridge_wr_data = value;
        next_random(value);
        cont1_key = value[15:0];
        cont2_key = value[31:16];
        pix_ce = ctl[4];
        if (ctl[7:5] == 3'd0) begin
            core_video.hs_n = !core_video.hs_n;
        end
        if (ctl[12:8] == 5'd0) begin
            core_video.vs_n = !core_video.vs_n;
        end
        core_video.hblank = (ctl[15:13] == 3'd0);
        core_video.vblank = (ctl[20:18] == 3'd0);
        core_video.r = ctl[23:21];
        core_video.g = ctl[26:24];
        core_video.b = ctl[28:27];
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        reset                 = 1'b1;
        bridge_addr           = 32'h0;
        bridge_wr             = 1'b0;
        bridge_wr_data        = 32'h0;
        dataslot_requestwrite = 1'b0;
        dataslot_allcomplete  = 1'b0;
        cont1_key             = '0;
        cont2_key             = '0;
        core_video            = '0;
        core_video.hs_n       = 1'b1;
        core_video.vs_n       = 1'b1;
        pix_ce                = 1'b0;
        rgb_known             = 1'b0;
        exp_rgb               = 24'h0;
        hs_expected           = 0;
        vs_expected           = 0;
        hs_seen               = 0;
        vs_seen               = 0;

        repeat (10) step_cycle();
        reset = 1'b0;

        // settings, keys and video all at once over a random frame
        repeat (800) begin
            drive_random();
            step_cycle();
        end
        compare(64'(hs_seen), 64'(hs_expected), "hs pulse count");
        compare(64'(vs_seen), 64'(vs_expected), "vs pulse count");
        compare(64'(vs_expected > 0), 64'(1), "any vs pulse in frame");
        bridge_wr = 1'b0;
        pix_ce    = 1'b0;
        step_cycle();

        // host reset request, second request mid-stretch is dropped
        bridge_addr    = addr_reset_req;
        bridge_wr_data = 32'h1;
        bridge_wr      = 1'b1;
        step_cycle();
        bridge_wr   = 1'b0;
        wait_cycles = 0;
        while (core_reset !== 1'b1) begin
            step_cycle();
            wait_cycles = wait_cycles + 1;
            if (wait_cycles > 10) begin
                report_timeout("core_reset to rise after a reset request");
            end
        end
        high_cycles = 0;
        while (core_reset === 1'b1) begin
            high_cycles = high_cycles + 1;
            bridge_wr   = (high_cycles == hold_len / 2);
            step_cycle();
            if (high_cycles > 2 * hold_len) begin
                report_timeout("core_reset to fall after the stretch");
            end
        end
        bridge_wr = 1'b0;
        compare(64'(high_cycles), 64'(hold_len), "stretch length");

        // rom download window
        dataslot_requestwrite = 1'b1;
        step_cycle();
        dataslot_requestwrite = 1'b0;
        wait_cycles = 0;
        while (core_reset !== 1'b1) begin
            step_cycle();
            wait_cycles = wait_cycles + 1;
            if (wait_cycles > 10) begin
                report_timeout("core_reset to rise on a download");
            end
        end
        next_random(word);
        repeat (int'(word[4:0]) + 5) step_cycle();
        dataslot_allcomplete = 1'b1;
        step_cycle();
        dataslot_allcomplete = 1'b0;
        compare(64'(core_reset), 64'(1), "core_reset right after allcomplete");
        step_cycle();
        compare(64'(core_reset), 64'(0), "core_reset after the download");
        repeat (4) step_cycle();

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/arcade_shell_top.sv */
// host-side shell of the arcade core, everything on clk_74a
// outputs feed the game core directly, all of them registered in the leaves

`timescale 1ns/1ps
`default_nettype none

module arcade_shell_top import shell_pkg::*, video_pkg::*; #(
    parameter int reset_hold_cycles = reset_hold_default
) (
    input  wire                  clk_74a,
    input  wire                  reset,
    // bridge write port
    input  wire  [31:0]          bridge_addr,
    input  wire                  bridge_wr,
    input  wire  [31:0]          bridge_wr_data,
    // data slot pulses from the host
    input  wire                  dataslot_requestwrite,
    input  wire                  dataslot_allcomplete,
    // controllers
    input  wire key_bits_t       cont1_key,
    input  wire key_bits_t       cont2_key,
    // core video
    input  wire core_video_t     core_video,
    input  wire                  pix_ce,
    // to the game core and scaler
    output wire  [dip_width-1:0] dip_sw,
    output wire                  btn_service_n,
    output wire                  core_reset,
    output game_inputs_t         game_in,
    output video_out_t           video
);

    // settings block to reset stretcher
    wire reset_req;

    ////////////////////////////////////////////////////////////////////////////
    // settings and reset
    dip_settings dip_settings0 (
        .clk_74a        (clk_74a),
        .reset          (reset),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .dip_sw         (dip_sw),
        .btn_service_n  (btn_service_n),
        .reset_req      (reset_req)
    );

    core_reset_ctl #(
        .hold_cycles (reset_hold_cycles)
    ) core_reset_ctl0 (
        .clk_74a               (clk_74a),
        .reset                 (reset),
        .reset_req             (reset_req),
        .dataslot_requestwrite (dataslot_requestwrite),
        .dataslot_allcomplete  (dataslot_allcomplete),
        .core_reset            (core_reset)
    );

    ////////////////////////////////////////////////////////////////////////////
    // inputs and video
    control_map control_map0 (
        .clk_74a   (clk_74a),
        .reset     (reset),
        .cont1_key (cont1_key),
        .cont2_key (cont2_key),
        .game_in   (game_in)
    );

    video_formatter video_formatter0 (
        .clk_74a    (clk_74a),
        .reset      (reset),
        .pix_ce     (pix_ce),
        .core_video (core_video),
        .video      (video)
    );

endmodule

`default_nettype wire

/* verilog/video_formatter.sv */
// 3-3-2 core video to 24-bit rgb sampled on pix_ce only
// outputs hold between pixel ticks
// syncs pulse for one tick on falling hs_n/vs_n
// no sync pulse on the first tick after reset

`timescale 1ns/1ps
`default_nettype none

module video_formatter import video_pkg::*; (
    input  wire              clk_74a,
    input  wire              reset,
    input  wire              pix_ce,
    input  wire core_video_t core_video,
    output video_out_t       video
);

    logic        active;
    logic [23:0] rgb_expanded;

    logic [23:0] rgb_q;
    logic        de_q;
    logic        hs_q;
    logic        vs_q;
    // sync levels seen on the previous tick
    logic        hs_n_prev;
    logic        vs_n_prev;

    ////////////////////////////////////////////////////////////////////////////
    // colour expansion by bit replication
    assign active = !(core_video.hblank || core_video.vblank);

    assign rgb_expanded = {
        core_video.r, core_video.r, core_video.r[red_width-1 -: 2],
        core_video.g, core_video.g, core_video.g[green_width-1 -: 2],
        {(8 / blue_width){core_video.b}}
    };

    // pixel data is black during blanking
    always_ff @(posedge clk_74a) begin
        if (pix_ce) begin
            rgb_q <= active ? rgb_expanded : '0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // data enable and sync edges
    always_ff @(posedge clk_74a) begin
        if (reset) begin
            de_q      <= 1'b0;
            hs_q      <= 1'b0;
            vs_q      <= 1'b0;
            hs_n_prev <= 1'b0;
            vs_n_prev <= 1'b0;
        end else if (pix_ce) begin
            de_q      <= active;
            // high to low on the core sync
            hs_q      <= hs_n_prev & ~core_video.hs_n;
            vs_q      <= vs_n_prev & ~core_video.vs_n;
            hs_n_prev <= core_video.hs_n;
            vs_n_prev <= core_video.vs_n;
        end
    end

    assign video = '{rgb: rgb_q, de: de_q, hs: hs_q, vs: vs_q};

    // each channel slice carries the colour seen on the active tick
    assert property (@(posedge clk_74a) disable iff (reset)
        pix_ce && active |=> video.de
            && (video.rgb[23:21] == $past(core_video.r))
            && (video.rgb[20:18] == $past(core_video.r))
            && (video.rgb[17:16] == $past(core_video.r[2:1]))
            && (video.rgb[15:13] == $past(core_video.g))
            && (video.rgb[12:10] == $past(core_video.g))
            && (video.rgb[9:8] == $past(core_video.g[2:1]))
            && (video.rgb[7:0] == {4{$past(core_video.b)}}));

endmodule

`default_nettype wire

/* verilog/control_map.sv */
// controller keys to game inputs, one register stage
// keys arrive already on clk_74a, no synchronizer here

`timescale 1ns/1ps
`default_nettype none

module control_map import shell_pkg::*; (
    input  wire          clk_74a,
    input  wire          reset,
    input  wire key_bits_t cont1_key,
    input  wire key_bits_t cont2_key,
    output game_inputs_t game_in
);

    // any face button fires
    function automatic logic fire(input key_bits_t key);
        fire = key.a | key.b | key.x | key.y;
    endfunction

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            game_in <= game_inputs_idle;
        end else begin
            // player 2 in the upper bit of coin and start
            game_in <= '{
                coin_n:    ~{cont2_key.select, cont1_key.select},
                start_n:   ~{cont2_key.start, cont1_key.start},
                p1_joy_n:  ~{cont1_key.right, cont1_key.left, cont1_key.down, cont1_key.up},
                p2_joy_n:  ~{cont2_key.right, cont2_key.left, cont2_key.down, cont2_key.up},
                p1_fire_n: ~fire(cont1_key),
                p2_fire_n: ~fire(cont2_key),
                // pause stays active high
                pause:     cont1_key.l1 | cont2_key.l1
            };
        end
    end

endmodule

`default_nettype wire

/* verilog/core_reset_ctl.sv */
// core reset from global reset, rom download window and a stretched host request
// a request during an active stretch is dropped, it does not restart the count
// hold_cycles must be at least 1

`timescale 1ns/1ps
`default_nettype none

module core_reset_ctl import shell_pkg::*; #(
    parameter int hold_cycles = reset_hold_default
) (
    input  wire  clk_74a,
    input  wire  reset,
    input  wire  reset_req,
    input  wire  dataslot_requestwrite,
    input  wire  dataslot_allcomplete,
    output logic core_reset
);

    localparam int                   count_bits = $clog2(hold_cycles + 1);
    localparam logic [count_bits-1:0] count_last = count_bits'(hold_cycles);

    logic                  downloading;
    logic                  stretch_active;
    logic [count_bits-1:0] hold_count;

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            downloading    <= 1'b0;
            stretch_active <= 1'b0;
            hold_count     <= '0;
            core_reset     <= 1'b1;
        end else begin
            // download window, open until all slots are done
            if (dataslot_requestwrite) begin
                downloading <= 1'b1;
            end else if (dataslot_allcomplete) begin
                downloading <= 1'b0;
            end

            // stretcher, count 1..hold_cycles then go idle
            if (!stretch_active) begin
                if (reset_req) begin
                    stretch_active <= 1'b1;
                    hold_count     <= count_bits'(1);
                end
            end else if (hold_count == count_last) begin
                stretch_active <= 1'b0;
                hold_count     <= '0;
            end else begin
                hold_count <= hold_count + count_bits'(1);
            end

            // registered, so each cause shows one cycle later
            core_reset <= downloading | stretch_active;
        end
    end

    assert property (@(posedge clk_74a) disable iff (reset)
        hold_count <= count_last);

endmodule

`default_nettype wire

/* verilog/dip_settings.sv */
// host menu settings decoded from bridge writes into the game dip word
// bridge_wr is a single-cycle strobe, one write per strobe
// reset_req is a one-cycle pulse, it does not toggle

`timescale 1ns/1ps
`default_nettype none

module dip_settings import shell_pkg::*; (
    input  wire                  clk_74a,
    input  wire                  reset,
    input  wire  [31:0]          bridge_addr,
    input  wire                  bridge_wr,
    input  wire  [31:0]          bridge_wr_data,
    output logic [dip_width-1:0] dip_sw,
    output logic                 btn_service_n,
    output logic                 reset_req
);

    // settings as written by the host, active high
    logic [1:0] ship_count;
    logic       cabinet;
    logic       bonus;
    logic [2:0] difficulty;
    logic       demo_sounds;
    logic       demo_music;
    logic       service;

    ////////////////////////////////////////////////////////////////////////////
    // write decode
    always_ff @(posedge clk_74a) begin
        if (reset) begin
            ship_count  <= '0;
            cabinet     <= 1'b0;
            bonus       <= 1'b0;
            difficulty  <= difficulty_default;
            demo_sounds <= 1'b0;
            demo_music  <= 1'b0;
            service     <= 1'b0;
            reset_req   <= 1'b0;
        end else begin
            // request only lives for one cycle
            reset_req <= 1'b0;
            if (bridge_wr) begin
                case (bridge_addr)
                    addr_ship_count:  ship_count  <= bridge_wr_data[1:0];
                    addr_cabinet:     cabinet     <= bridge_wr_data[0];
                    addr_bonus:       bonus       <= bridge_wr_data[0];
                    addr_difficulty:  difficulty  <= bridge_wr_data[2:0];
                    addr_demo_sounds: demo_sounds <= bridge_wr_data[0];
                    addr_demo_music:  demo_music  <= bridge_wr_data[0];
                    addr_service:     service     <= bridge_wr_data[0];
                    addr_reset_req:   reset_req   <= 1'b1;
                    // unknown address, drop it
                    default: ;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // dip word, switches are active low on the board
    // two pad bytes at the bottom, one at the top
    assign dip_sw = {
        dip_pad,
        7'h7f,
        ~demo_music,
        ~demo_sounds,
        ~difficulty,
        ~bonus,
        ~cabinet,
        ~ship_count,
        dip_pad,
        dip_pad
    };

    assign btn_service_n = ~service;

    // host strobes are single cycle, so the pulse never stretches
    assert property (@(posedge clk_74a) disable iff (reset)
        reset_req |=> !reset_req);

endmodule

`default_nettype wire

/* verilog/video_pkg.sv */
// video types for the core side (3-3-2 colour) and the scaler side (24-bit rgb)
// core syncs are active low, scaler syncs are single-tick active high pulses

`default_nettype none

package video_pkg;

    // core colour depth
    localparam int red_width   = 3;
    localparam int green_width = 3;
    localparam int blue_width  = 2;

    // raw video from the game core
    typedef struct packed {
        logic [red_width-1:0]   r;
        logic [green_width-1:0] g;
        logic [blue_width-1:0]  b;
        logic                   hblank;
        logic                   vblank;
        logic                   hs_n;
        logic                   vs_n;
    } core_video_t;

    // video to the scaler
    typedef struct packed {
        logic [23:0] rgb;
        logic        de;
        logic        hs;
        logic        vs;
    } video_out_t;

endpackage

`default_nettype wire

/* verilog/shell_pkg.sv */
// shared definitions for the host-side shell, one clock domain only
// bridge addresses are matched on the full 32-bit word, no masking
// reset hold length is in clk_74a cycles

`default_nettype none

package shell_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bridge address map, settings written by the host menu
    localparam logic [31:0] addr_ship_count  = 32'h8000_0000;
    localparam logic [31:0] addr_cabinet     = 32'h4000_0000;
    localparam logic [31:0] addr_bonus       = 32'h9000_0000;
    localparam logic [31:0] addr_difficulty  = 32'h1000_0000;
    localparam logic [31:0] addr_demo_sounds = 32'h5000_0000;
    localparam logic [31:0] addr_demo_music  = 32'h6000_0000;
    localparam logic [31:0] addr_service     = 32'h2000_0000;
    localparam logic [31:0] addr_reset_req   = 32'h3000_0000;

    // dip word defaults and layout
    localparam logic [2:0] difficulty_default = 3'd3;
    localparam int         dip_width          = 40;
    localparam logic [7:0] dip_pad            = 8'hff;

    // about 28 ms at 74.25 mhz
    localparam int reset_hold_default = 2097151;

    ////////////////////////////////////////////////////////////////////////////
    // controller key bitmap, msb first, bit 0 is dpad up
    typedef struct packed {
        logic start;
        logic select;
        logic r3;
        logic l3;
        logic r2;
        logic l2;
        logic r1;
        logic l1;
        logic y;
        logic x;
        logic b;
        logic a;
        logic right;
        logic left;
        logic down;
        logic up;
    } key_bits_t;

    // game inputs, active low except pause
    // joystick order is right, left, down, up
    typedef struct packed {
        logic [1:0] coin_n;
        logic [1:0] start_n;
        logic [3:0] p1_joy_n;
        logic [3:0] p2_joy_n;
        logic       p1_fire_n;
        logic       p2_fire_n;
        logic       pause;
    } game_inputs_t;

    // nothing pressed
    localparam game_inputs_t game_inputs_idle = '{
        coin_n:    2'b11,
        start_n:   2'b11,
        p1_joy_n:  4'hf,
        p2_joy_n:  4'hf,
        p1_fire_n: 1'b1,
        p2_fire_n: 1'b1,
        pause:     1'b0
    };

endpackage

`default_nettype wire
